// File: project.f
chiplet_types_pkg.sv
switch_if.sv
buf_port_if.sv
socetlib_counter.sv
crc_accum.sv
rx_fsm.sv
buf_arbiter.sv
pkt_buffer.sv
host_reader.sv
rx_endpoint_top.sv
rx_endpoint_props.sv
tb_rx_endpoint.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rx endpoint testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_rx_endpoint -f project.f -o tb_rx_endpoint
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_rx_endpoint > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0

// File: tb_rx_endpoint.sv
`timescale 1ns/1ps

module tb_rx_endpoint;
    localparam int BUF_AW     = 7;
    localparam int DESC_DEPTH = 4;
    localparam int TIMEOUT    = 5000;

    logic        clk;
    logic        n_rst;
    logic        flit_valid;
    logic [31:0] flit_data;
    logic [3:0]  flit_src;
    logic        rd_en;
    logic        rd_valid;
    logic [31:0] rd_data;
    logic        rd_last;
    logic [3:0]  rd_src;

    logic [31:0] rng;
    logic        rd_en_random;

    // expected host words as {last, src, data}, written by the driver only
    logic [36:0] exp_words [2048];
    logic [36:0] exp_word;
    int exp_wr, exp_rd;
    int committed, pkts_seen;
    int errors, mon_errors;
    int test_count, test_fails;
    int err_start, pkts_start;

    rx_endpoint_top #(.BUF_AW(BUF_AW), .DESC_DEPTH(DESC_DEPTH)) DUT (
        .clk(clk),
        .n_rst(n_rst),
        .flit_valid(flit_valid),
        .flit_data(flit_data),
        .flit_src(flit_src),
        .rd_en(rd_en),
        .rd_valid(rd_valid),
        .rd_data(rd_data),
        .rd_last(rd_last),
        .rd_src(rd_src)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r % 32'(n));
    endfunction

    // reference crc-32, poly 04C11DB7, msb first, no reflection
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [31:0] w);
        logic [31:0] c;
        c = crc;
        for (int b = 31; b >= 0; b--) begin
            if (c[31] ^ w[b]) begin
                c = (c << 1) ^ 32'h04C1_1DB7;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    function automatic int total_errors();
        return errors + mon_errors;
    endfunction

    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #5;
        if (rd_en_random) begin
            r = next_rand();
            rd_en = r[0] | r[1];
        end
    endtask

    task automatic settle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic drive_flit(input logic [31:0] w, input logic [3:0] node);
        flit_valid = 1'b1;
        flit_data  = w;
        flit_src   = node;
        next_cycle();
        flit_valid = 1'b0;
    endtask

    // header, data flits, then the crc flit; the model decides commit at the crc flit
    task automatic send_packet(input int len, input logic [3:0] node, input bit corrupt,
                               input int max_gap);
        logic [31:0] r, w, crc;
        logic [36:0] words [$];
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i <= len; i++) begin
            r = next_rand();
            if (i == 0) begin
                w = {r[31:12], node, r[7:4], 4'(len)};
            end else begin
                w = r;
            end
            crc = crc_step(crc, w);
            words.push_back({(i == len), node, w});
            settle(rand_below(max_gap + 1));
            drive_flit(w, node);
        end
        r = next_rand();
        settle(rand_below(max_gap + 1));
        if (corrupt) begin
            w = crc ^ (r | 32'h1);
        end else begin
            w = crc;
        end
        // overflow is judged in the crc flit cycle
        if (!corrupt && (committed - pkts_seen) < DESC_DEPTH) begin
            while (words.size() != 0) begin
                exp_words[exp_wr] = words.pop_front();
                exp_wr++;
            end
            committed++;
        end
        drive_flit(w, node);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_rd != exp_wr && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (exp_rd != exp_wr) begin
            $display("timeout: %0d expected words never reached the host port", exp_wr - exp_rd);
            errors++;
        end
        // quiet window to catch words from dropped packets
        settle(40);
    endtask

    task automatic end_test(input string name, input int start);
        int n;
        n = total_errors() - start;
        test_count++;
        if (n == 0) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            test_fails++;
            $display("test %0d %s: %0d errors", test_count, name, n);
        end
    endtask

    // output monitor, sampled away from the rising edge
    always @(negedge clk) begin
        if (n_rst && rd_valid) begin
            if (exp_rd == exp_wr) begin
                $display("ERR @%0t: word %h came out with nothing expected", $time, rd_data);
                mon_errors++;
            end else begin
                exp_word = exp_words[exp_rd];
                exp_rd++;
                if (rd_data !== exp_word[31:0]) begin
                    $display("ERR @%0t: rd_data %h, expected %h", $time, rd_data, exp_word[31:0]);
                    mon_errors++;
                end
                if (rd_last !== exp_word[36]) begin
                    $display("ERR @%0t: rd_last %b, expected %b", $time, rd_last, exp_word[36]);
                    mon_errors++;
                end
                if (rd_src !== exp_word[35:32]) begin
                    $display("ERR @%0t: rd_src %h, expected %h", $time, rd_src, exp_word[35:32]);
                    mon_errors++;
                end
            end
            if (rd_last) begin
                pkts_seen++;
            end
        end else if (n_rst && rd_last) begin
            $display("ERR @%0t: rd_last high without rd_valid", $time);
            mon_errors++;
        end
    end

    initial begin
        rng          = 32'h56d8_3f2d;
        n_rst        = 1'b0;
        flit_valid   = 1'b0;
        flit_data    = '0;
        flit_src     = '0;
        rd_en        = 1'b0;
        rd_en_random = 1'b0;
        exp_wr       = 0;
        exp_rd       = 0;
        committed    = 0;
        pkts_seen    = 0;
        errors       = 0;
        mon_errors   = 0;
        test_count   = 0;
        test_fails   = 0;
        repeat (3) @(posedge clk);
        #5;
        n_rst = 1'b1;

        err_start = total_errors();
        settle(20);
        end_test("idle after reset", err_start);

        err_start = total_errors();
        rd_en = 1'b1;
        send_packet(5, 4'h3, 1'b0, 0);
        wait_drain();
        end_test("single good packet", err_start);

        // the good packet reuses the rewound space
        err_start = total_errors();
        send_packet(6, 4'h9, 1'b1, 1);
        send_packet(3, 4'h5, 1'b0, 1);
        wait_drain();
        end_test("bad crc then good packet", err_start);

        err_start = total_errors();
        rd_en = 1'b0;
        pkts_start = pkts_seen;
        for (int i = 0; i <= DESC_DEPTH; i++) begin
            send_packet(1 + rand_below(15), 4'(i + 1), 1'b0, 0);
        end
        settle(5);
        rd_en = 1'b1;
        wait_drain();
        if (pkts_seen - pkts_start != DESC_DEPTH) begin
            $display("ERR @%0t: %0d packets came out, expected %0d", $time,
                     pkts_seen - pkts_start, DESC_DEPTH);
            errors++;
        end
        end_test("descriptor queue full", err_start);

        err_start = total_errors();
        rd_en_random = 1'b1;
        for (int i = 0; i < 40; i++) begin
            send_packet(rand_below(16), 4'(rand_below(16)), (rand_below(4) == 0), 3);
        end
        rd_en_random = 1'b0;
        rd_en = 1'b1;
        wait_drain();
        end_test("random stream", err_start);

        $display("tests %0d, failed %0d, errors %0d, words checked %0d",
                 test_count, test_fails, total_errors(), exp_rd);
        if (total_errors() == 0 && test_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end
endmodule

// File: rx_endpoint_props.sv
`timescale 1ns/1ps

module rx_endpoint_props (
    input logic clk,
    input logic n_rst,
    input logic fifo_enable,
    input logic rewind,
    input logic in_idle,
    input logic rx_gnt,
    input logic host_gnt
);
    // descriptor push is a single-cycle strobe
    fifo_pulse: assert property (@(posedge clk) disable iff (!n_rst)
        fifo_enable |=> !fifo_enable)
        else $error("fifo_enable high for more than one cycle");

    grant_excl: assert property (@(posedge clk) disable iff (!n_rst)
        !(rx_gnt && host_gnt))
        else $error("rx and host granted in the same cycle");

    rewind_idle: assert property (@(posedge clk) disable iff (!n_rst)
        rewind |=> in_idle)
        else $error("state not IDLE after a rewind");
endmodule

// fsm side, grant inputs unused here
bind rx_fsm rx_endpoint_props fsm_props (
    .clk(clk),
    .n_rst(n_rst),
    .fifo_enable(fifo_enable),
    .rewind(rewind),
    .in_idle(state == IDLE),
    .rx_gnt(1'b0),
    .host_gnt(1'b0)
);

bind buf_arbiter rx_endpoint_props arb_props (
    .clk(clk),
    .n_rst(n_rst),
    .fifo_enable(1'b0),
    .rewind(1'b0),
    .in_idle(1'b1),
    .rx_gnt(rx_port.gnt),
    .host_gnt(host_port.gnt)
);

// File: rx_endpoint_top.sv
`timescale 1ns/1ps

module rx_endpoint_top #(
    parameter int BUF_AW     = 7,
    parameter int DESC_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        flit_valid,
    input  chiplet_types_pkg::word_t    flit_data,
    input  chiplet_types_pkg::node_id_t flit_src,
    input  logic                        rd_en,
    output logic                        rd_valid,
    output chiplet_types_pkg::word_t    rd_data,
    output logic                        rd_last,
    output chiplet_types_pkg::node_id_t rd_src
);
    switch_if sw_bus ();
    buf_port_if #(.BUF_AW(BUF_AW)) rx_bus ();
    buf_port_if #(.BUF_AW(BUF_AW)) host_bus ();

    logic crc_clear, crc_update, fifo_enable, overflow;
    chiplet_types_pkg::word_t crc_val;
    chiplet_types_pkg::desc_t desc;
    logic mem_en, mem_we;
    logic [BUF_AW-1:0] mem_addr;
    chiplet_types_pkg::word_t mem_wdata, mem_rdata;

    // switch side of channel 0
    assign sw_bus.data_ready = flit_valid;
    assign sw_bus.payload    = flit_data;
    assign sw_bus.req        = flit_src;

    rx_fsm #(.BUF_AW(BUF_AW)) u_rx_fsm (
        .clk(clk),
        .n_rst(n_rst),
        .sw(sw_bus.endpoint),
        .wr(rx_bus.client),
        .overflow(overflow),
        .crc_val(crc_val),
        .crc_clear(crc_clear),
        .crc_update(crc_update),
        .fifo_enable(fifo_enable),
        .desc(desc),
        .req()
    );

    crc_accum u_crc (
        .clk(clk),
        .n_rst(n_rst),
        .crc_clear(crc_clear),
        .crc_update(crc_update),
        .data(sw_bus.payload),
        .crc_val(crc_val)
    );

    buf_arbiter #(.BUF_AW(BUF_AW)) u_arb (
        .clk(clk),
        .n_rst(n_rst),
        .rx_port(rx_bus.arbiter),
        .host_port(host_bus.arbiter),
        .mem_en(mem_en),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    pkt_buffer #(.BUF_AW(BUF_AW)) u_buf (
        .clk(clk),
        .en(mem_en),
        .we(mem_we),
        .addr(mem_addr),
        .wdata(mem_wdata),
        .rdata(mem_rdata)
    );

    host_reader #(.BUF_AW(BUF_AW), .DESC_DEPTH(DESC_DEPTH)) u_host (
        .clk(clk),
        .n_rst(n_rst),
        .fifo_enable(fifo_enable),
        .desc(desc),
        .overflow(overflow),
        .rd(host_bus.client),
        .rd_en(rd_en),
        .rd_valid(rd_valid),
        .rd_data(rd_data),
        .rd_last(rd_last),
        .rd_src(rd_src)
    );
endmodule

// File: host_reader.sv
`timescale 1ns/1ps

module host_reader #(
    parameter int BUF_AW     = 7,
    parameter int DESC_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        fifo_enable,
    input  chiplet_types_pkg::desc_t    desc,
    output logic                        overflow,
    buf_port_if.client                  rd,
    input  logic                        rd_en,
    output logic                        rd_valid,
    output chiplet_types_pkg::word_t    rd_data,
    output logic                        rd_last,
    output chiplet_types_pkg::node_id_t rd_src
);
    localparam int QW = (DESC_DEPTH > 1) ? $clog2(DESC_DEPTH) : 1;
    localparam int CW = $clog2(DESC_DEPTH + 1);

    chiplet_types_pkg::desc_t queue [DESC_DEPTH];
    chiplet_types_pkg::desc_t head;
    logic [QW-1:0] wr_idx, rd_idx;
    logic [CW-1:0] used;
    logic [chiplet_types_pkg::DESC_COUNT_WIDTH-1:0] word_cnt;
    logic push, pop, issue_done, rd_go, last_go;
    logic rd_pend, last_pend;

    // head stays queued until its last word has left
    assign head     = queue[rd_idx];
    assign overflow = (used == CW'(DESC_DEPTH));
    assign push     = fifo_enable && !overflow;
    assign pop      = rd_valid && rd_last;
    assign rd_src   = head.node;

    assign rd.en    = (used != '0) && !issue_done && rd_en;
    assign rd.we    = 1'b0;
    assign rd.wdata = '0;
    // wraps with the ring
    assign rd.addr  = head.start[BUF_AW-1:0] + BUF_AW'(word_cnt);
    assign rd_go    = rd.en && rd.gnt;

    socetlib_counter #(.NBITS(chiplet_types_pkg::DESC_COUNT_WIDTH)) word_counter (
        .clk(clk),
        .n_rst(n_rst),
        .clear(pop),
        .count_enable(rd_go),
        .overflow_val(head.count),
        .count_out(word_cnt),
        .overflow_flag(last_go)
    );

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_idx] <= desc;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_idx     <= '0;
            rd_idx     <= '0;
            used       <= '0;
            issue_done <= 1'b0;
            rd_pend    <= 1'b0;
            last_pend  <= 1'b0;
            rd_valid   <= 1'b0;
            rd_last    <= 1'b0;
        end else begin
            if (push) begin
                wr_idx <= (wr_idx == QW'(DESC_DEPTH - 1)) ? '0 : wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= (rd_idx == QW'(DESC_DEPTH - 1)) ? '0 : rd_idx + 1'b1;
            end
            used <= used + CW'(push) - CW'(pop);
            if (pop) begin
                issue_done <= 1'b0;
            end else if (last_go) begin
                issue_done <= 1'b1;
            end
            // two-stage return path, memory then output register
            rd_pend   <= rd_go;
            last_pend <= last_go;
            rd_valid  <= rd_pend;
            rd_last   <= last_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend) begin
            rd_data <= rd.rdata;
        end
    end
endmodule

// File: pkt_buffer.sv
`timescale 1ns/1ps

module pkt_buffer #(
    parameter int BUF_AW = 7
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [BUF_AW-1:0]        addr,
    input  chiplet_types_pkg::word_t wdata,
    output chiplet_types_pkg::word_t rdata
);
    chiplet_types_pkg::word_t mem [2**BUF_AW];

    // single port, read data registered
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end
endmodule

// File: buf_arbiter.sv
`timescale 1ns/1ps

module buf_arbiter #(
    parameter int BUF_AW = 7
) (
    input  logic                     clk,
    input  logic                     n_rst,
    buf_port_if.arbiter              rx_port,
    buf_port_if.arbiter              host_port,
    output logic                     mem_en,
    output logic                     mem_we,
    output logic [BUF_AW-1:0]        mem_addr,
    output chiplet_types_pkg::word_t mem_wdata,
    input  chiplet_types_pkg::word_t mem_rdata
);
    logic host_sel;
    logic rx_rd_q, host_rd_q;

    // rx always wins
    assign rx_port.gnt   = rx_port.en;
    assign host_sel      = host_port.en && !rx_port.en;
    assign host_port.gnt = host_sel;

    assign mem_en    = rx_port.en || host_sel;
    assign mem_we    = host_sel ? host_port.we    : rx_port.we;
    assign mem_addr  = host_sel ? host_port.addr  : rx_port.addr;
    assign mem_wdata = host_sel ? host_port.wdata : rx_port.wdata;

    // remember who read, the data comes back one cycle later
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rx_rd_q   <= 1'b0;
            host_rd_q <= 1'b0;
        end else begin
            rx_rd_q   <= rx_port.en && !rx_port.we;
            host_rd_q <= host_sel && !host_port.we;
        end
    end

    assign rx_port.rdata   = rx_rd_q   ? mem_rdata : '0;
    assign host_port.rdata = host_rd_q ? mem_rdata : '0;
endmodule

// File: rx_fsm.sv
`timescale 1ns/1ps

module rx_fsm #(
    parameter int BUF_AW = 7
) (
    input  logic                        clk,
    input  logic                        n_rst,
    switch_if.endpoint                  sw,
    buf_port_if.client                  wr,
    input  logic                        overflow,
    input  chiplet_types_pkg::word_t    crc_val,
    output logic                        crc_clear,
    output logic                        crc_update,
    output logic                        fifo_enable,
    output chiplet_types_pkg::desc_t    desc,
    output chiplet_types_pkg::node_id_t req
);
    typedef enum logic [1:0] {
        IDLE,
        GET_LENGTH,
        CRC_CHECK,
        REQ_EN
    } state_e;

    state_e state, next_state;
    logic [chiplet_types_pkg::PKT_LENGTH_WIDTH-1:0] curr_pkt_length;
    logic [chiplet_types_pkg::PKT_LENGTH_WIDTH-1:0] hdr_length;
    logic [BUF_AW-1:0] cache_addr, next_cache_addr, pkt_start;
    logic cache_enable, count_enable, length_clear, length_done;
    logic hdr_accept, rewind;

    socetlib_counter #(.NBITS(chiplet_types_pkg::PKT_LENGTH_WIDTH)) length_counter (
        .clk(clk),
        .n_rst(n_rst),
        .clear(length_clear),
        .count_enable(count_enable),
        .overflow_val(curr_pkt_length),
        .count_out(),
        .overflow_flag(length_done)
    );

    assign hdr_length = chiplet_types_pkg::expected_num_flits(sw.payload);

    // a header may also land in the commit cycle
    assign hdr_accept = sw.data_ready && (state == IDLE || state == REQ_EN);

    // bad crc or no room in the descriptor queue
    assign rewind = (state == CRC_CHECK) && sw.data_ready
                    && ((sw.payload != crc_val) || overflow);

    assign wr.en    = cache_enable;
    assign wr.we    = cache_enable;
    assign wr.addr  = cache_addr;
    assign wr.wdata = sw.payload;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state      <= IDLE;
            cache_addr <= '0;
        end else begin
            state      <= next_state;
            cache_addr <= next_cache_addr;
        end
    end

    // packet fields, latched with the header
    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            pkt_start       <= cache_addr;
            curr_pkt_length <= hdr_length;
            req             <= sw.req;
        end
    end

    always_comb begin
        next_state      = state;
        next_cache_addr = cache_addr;
        cache_enable    = 1'b0;
        count_enable    = 1'b0;
        length_clear    = 1'b0;
        crc_clear       = 1'b0;
        crc_update      = 1'b0;
        fifo_enable     = 1'b0;
        case (state)
            GET_LENGTH: begin
                if (sw.data_ready) begin
                    cache_enable    = 1'b1;
                    crc_update      = 1'b1;
                    count_enable    = 1'b1;
                    next_cache_addr = cache_addr + 1'b1;
                    if (length_done) begin
                        next_state = CRC_CHECK;
                    end
                end
            end
            CRC_CHECK: begin
                if (rewind) begin
                    next_cache_addr = pkt_start;
                    next_state      = IDLE;
                end else if (sw.data_ready) begin
                    next_state = REQ_EN;
                end
            end
            REQ_EN: begin
                fifo_enable  = 1'b1;
                length_clear = 1'b1;
                next_state   = IDLE;
            end
            default: begin
            end
        endcase

        if (hdr_accept) begin
            cache_enable    = 1'b1;
            crc_clear       = 1'b1;
            crc_update      = 1'b1;
            length_clear    = 1'b1;
            next_cache_addr = cache_addr + 1'b1;
            // zero-length packets skip straight to the crc flit
            next_state      = (hdr_length == '0) ? CRC_CHECK : GET_LENGTH;
        end
    end

    always_comb begin
        desc       = '0;
        desc.start[BUF_AW-1:0] = pkt_start;
        // stored words include the header
        desc.count = {1'b0, curr_pkt_length} + 1'b1;
        desc.node  = req;
    end
endmodule

// File: crc_accum.sv
`timescale 1ns/1ps

module crc_accum (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     crc_clear,
    input  logic                     crc_update,
    input  chiplet_types_pkg::word_t data,
    output chiplet_types_pkg::word_t crc_val
);
    chiplet_types_pkg::word_t seed;

    // clear plus update starts a fresh crc that already holds the word
    assign seed = crc_clear ? chiplet_types_pkg::CRC_INIT : crc_val;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_val <= chiplet_types_pkg::CRC_INIT;
        end else if (crc_update) begin
            crc_val <= chiplet_types_pkg::crc_next(seed, data);
        end else if (crc_clear) begin
            crc_val <= chiplet_types_pkg::CRC_INIT;
        end
    end
endmodule

// File: socetlib_counter.sv
`timescale 1ns/1ps

module socetlib_counter #(
    parameter int NBITS = 4
) (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             clear,
    input  logic             count_enable,
    input  logic [NBITS-1:0] overflow_val,
    output logic [NBITS-1:0] count_out,
    output logic             overflow_flag
);
    logic [NBITS-1:0] count_inc;

    assign count_inc = count_out + 1'b1;

    // flags the enabled cycle whose count reaches the terminal value
    assign overflow_flag = !clear && count_enable && (count_inc == overflow_val);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count_out <= '0;
        end else if (clear || overflow_flag) begin
            count_out <= '0;
        end else if (count_enable) begin
            count_out <= count_inc;
        end
    end
endmodule

// File: buf_port_if.sv
`timescale 1ns/1ps

// one client's view of the shared packet buffer
interface buf_port_if #(
    parameter int BUF_AW = 7
);
    logic                     en;
    logic                     we;
    logic [BUF_AW-1:0]        addr;
    chiplet_types_pkg::word_t wdata;
    logic                     gnt;
    chiplet_types_pkg::word_t rdata;

    modport client (
        output en,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );
endinterface

// File: switch_if.sv
`timescale 1ns/1ps

// channel 0 flit lane from the switch
interface switch_if;
    logic                        data_ready;
    chiplet_types_pkg::word_t    payload;
    chiplet_types_pkg::node_id_t req;

    modport switch (
        output data_ready,
        output payload,
        output req
    );

    modport endpoint (
        input data_ready,
        input payload,
        input req
    );
endinterface

// File: chiplet_types_pkg.sv
package chiplet_types_pkg;

    // one flit or one buffer word
    typedef logic [31:0] word_t;

    // source node, carried in header bits 11..8
    typedef logic [3:0] node_id_t;

    localparam int PKT_LENGTH_WIDTH = 4;
    localparam int DESC_ADDR_WIDTH = 16;
    // header plus up to 15 data flits
    localparam int DESC_COUNT_WIDTH = PKT_LENGTH_WIDTH + 1;

    localparam word_t CRC_INIT = 32'hFFFF_FFFF;
    localparam word_t CRC_POLY = 32'h04C1_1DB7;

    typedef struct packed {
        logic [DESC_ADDR_WIDTH-1:0]  start;
        logic [DESC_COUNT_WIDTH-1:0] count;
        node_id_t                    node;
    } desc_t;

    // data flit count from header bits 3..0
    function automatic logic [PKT_LENGTH_WIDTH-1:0] expected_num_flits(input word_t hdr);
        return hdr[PKT_LENGTH_WIDTH-1:0];
    endfunction

    // crc-32, msb first, no reflection
    function automatic word_t crc_next(input word_t crc, input word_t data);
        word_t c;
        logic  fb;
        c = crc;
        for (int i = 31; i >= 0; i--) begin
            fb = c[31] ^ data[i];
            c = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

endpackage
